//--- htable_pkg.sv
//--------------------------------------------------------------------
// Shared widths, table geometry, hash and bus types for the lookup block
// Hash fold is fixed to 6 bits, so TABLE_DEPTH must stay at 64
// Seed of table 0 is zero, so its hash is the plain key fold
//--------------------------------------------------------------------
package htable_pkg;

    // Key and value widths
    localparam int KEY_W       = 16;
    localparam int VALUE_W     = 16;

    // Table geometry
    localparam int NUM_TABLES  = 3;
    localparam int TABLE_DEPTH = 64;
    localparam int HASH_W      = $clog2(TABLE_DEPTH);
    localparam int TBL_IDX_W   = $clog2(NUM_TABLES);

    typedef logic [KEY_W-1:0]      key_t;
    typedef logic [VALUE_W-1:0]    value_t;
    typedef logic [HASH_W-1:0]     hash_t;
    typedef logic [NUM_TABLES-1:0] tbl_mask_t;
    typedef logic [TBL_IDX_W-1:0]  tbl_idx_t;

    // One seed per table, so each table spreads keys differently
    localparam key_t HASH_SEED [NUM_TABLES] = '{16'h0000, 16'ha5c3, 16'h3b96};

    typedef enum logic {
        MODE_BROADCAST,
        MODE_ROUND_ROBIN
    } insert_mode_e;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOOKUP,
        OP_UPDATE
    } bus_op_e;

    typedef enum logic {
        GRANT_LOOKUP,
        GRANT_UPDATE
    } grant_e;

    // One memory word, 33 bits
    typedef struct packed {
        logic   valid;
        key_t   key;
        value_t value;
    } htable_entry_t;

    // Granted request as driven by the arbiter
    typedef struct packed {
        bus_op_e      op;
        key_t         key;
        value_t       value;
        insert_mode_e mode;
    } bus_req_t;

    // Word seen by every core
    typedef struct packed {
        bus_op_e   op;
        key_t      key;
        value_t    value;
        tbl_mask_t wr_mask;
    } bus_word_t;

    typedef struct packed {
        logic   ack;
        logic   hit;
        value_t value;
        logic   is_update;
    } core_rsp_t;

    // Salt the key with the table seed, then fold 16 bits down to 6
    function automatic hash_t htable_hash(input key_t key, input int tbl);
        key_t salted;
        salted = key ^ HASH_SEED[tbl];
        return salted[5:0] ^ salted[11:6] ^ {2'b00, salted[15:12]};
    endfunction

endpackage : htable_pkg

//--- htable_mem.sv
//--------------------------------------------------------------------
// Single-port table memory, 64 words of one entry each
// Write lands at the clock edge, read data is registered one cycle later
// Read register holds its value on write cycles and idle cycles
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_mem (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      en,
    input  logic                      wr,
    input  htable_pkg::hash_t         addr,
    input  htable_pkg::htable_entry_t wr_data,
    output htable_pkg::htable_entry_t rd_data
);

    htable_pkg::htable_entry_t mem_array [htable_pkg::TABLE_DEPTH];

    // Storage array
    always_ff @(posedge clk) begin
        if (en && wr) begin
            mem_array[addr] <= wr_data;
        end
    end

    // Registered read port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (en && !wr) begin
            rd_data <= mem_array[addr];
        end
    end

endmodule : htable_mem

//--- htable_arb.sv
//--------------------------------------------------------------------
// Grants the shared table bus to one lookup or one update per cycle
// Strobes are accepted only while the matching rdy level is high
// Under contention the source not granted last wins, lookup goes first
// after reset, and the loser waits one cycle in its slot
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_arb (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     init_done,
    input  logic                     lookup_req,
    input  htable_pkg::key_t         lookup_key,
    input  logic                     update_req,
    input  htable_pkg::key_t         update_key,
    input  htable_pkg::value_t       update_value,
    input  htable_pkg::insert_mode_e update_mode,
    output logic                     lookup_rdy,
    output logic                     update_rdy,
    output htable_pkg::bus_req_t     bus_req
);

    // Pending slots, one per source
    logic                     lk_pend;
    htable_pkg::key_t         lk_pend_key;
    logic                     up_pend;
    htable_pkg::key_t         up_pend_key;
    htable_pkg::value_t       up_pend_value;
    htable_pkg::insert_mode_e up_pend_mode;

    htable_pkg::grant_e       last_grant;

    logic                     lk_strobe;
    logic                     up_strobe;
    logic                     lk_have;
    logic                     up_have;
    logic                     grant_lk;
    logic                     grant_up;

    // Request seen this cycle, from the slot or straight from the inputs
    htable_pkg::key_t         lk_key;
    htable_pkg::key_t         up_key;
    htable_pkg::value_t       up_value;
    htable_pkg::insert_mode_e up_mode;

    assign lookup_rdy = init_done & ~lk_pend;
    assign update_rdy = init_done & ~up_pend;

    assign lk_strobe  = lookup_req & lookup_rdy;
    assign up_strobe  = update_req & update_rdy;
    assign lk_have    = lk_pend | lk_strobe;
    assign up_have    = up_pend | up_strobe;

    assign lk_key     = lk_pend ? lk_pend_key : lookup_key;
    assign up_key     = up_pend ? up_pend_key : update_key;
    assign up_value   = up_pend ? up_pend_value : update_value;
    assign up_mode    = up_pend ? up_pend_mode : update_mode;

    // ----------------------------------------------------------------
    // Grant decision
    // ----------------------------------------------------------------
    always_comb begin
        grant_lk = 1'b0;
        grant_up = 1'b0;
        if (lk_have && up_have) begin
            // Alternate against the last winner
            if (last_grant == htable_pkg::GRANT_LOOKUP) begin
                grant_up = 1'b1;
            end else begin
                grant_lk = 1'b1;
            end
        end else begin
            grant_lk = lk_have;
            grant_up = up_have;
        end
    end

    // Slot control, grant history and bus register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lk_pend    <= 1'b0;
            up_pend    <= 1'b0;
            last_grant <= htable_pkg::GRANT_UPDATE;
            bus_req    <= '0;
        end else begin
            // Loser stays in, or moves into, its slot
            lk_pend <= lk_have & ~grant_lk;
            up_pend <= up_have & ~grant_up;
            if (grant_lk) begin
                last_grant <= htable_pkg::GRANT_LOOKUP;
            end else if (grant_up) begin
                last_grant <= htable_pkg::GRANT_UPDATE;
            end
            if (grant_lk) begin
                bus_req.op <= htable_pkg::OP_LOOKUP;
            end else if (grant_up) begin
                bus_req.op <= htable_pkg::OP_UPDATE;
            end else begin
                bus_req.op <= htable_pkg::OP_NONE;
            end
            bus_req.key   <= grant_lk ? lk_key : up_key;
            bus_req.value <= up_value;
            bus_req.mode  <= up_mode;
        end
    end

    // Slot payload, captured on every accepted strobe
    always_ff @(posedge clk) begin
        if (lk_strobe) begin
            lk_pend_key <= lookup_key;
        end
        if (up_strobe) begin
            up_pend_key   <= update_key;
            up_pend_value <= update_value;
            up_pend_mode  <= update_mode;
        end
    end

endmodule : htable_arb

//--- htable_update_dist.sv
//--------------------------------------------------------------------
// Turns the insert mode of each update into a per-table write mask
// Round-robin pointer starts at table 0 and only moves on
// round-robin updates, broadcast updates leave it alone
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_update_dist (
    input  logic                  clk,
    input  logic                  arst_n,
    input  htable_pkg::bus_req_t  bus_req,
    output htable_pkg::bus_word_t bus_word
);

    htable_pkg::tbl_idx_t rr_ptr;
    logic                 rr_advance;

    assign rr_advance = (bus_req.op == htable_pkg::OP_UPDATE) &&
                        (bus_req.mode == htable_pkg::MODE_ROUND_ROBIN);

    always_comb begin
        bus_word.op      = bus_req.op;
        bus_word.key     = bus_req.key;
        bus_word.value   = bus_req.value;
        // Lookups never write
        bus_word.wr_mask = '0;
        if (bus_req.op == htable_pkg::OP_UPDATE) begin
            if (bus_req.mode == htable_pkg::MODE_BROADCAST) begin
                bus_word.wr_mask = '1;
            end else begin
                bus_word.wr_mask = htable_pkg::tbl_mask_t'(1) << rr_ptr;
            end
        end
    end

    // Pointer wraps after the last table
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_ptr <= '0;
        end else if (rr_advance) begin
            if (rr_ptr == htable_pkg::tbl_idx_t'(htable_pkg::NUM_TABLES - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

endmodule : htable_update_dist

//--- htable_core.sv
//--------------------------------------------------------------------
// One hash table with its clear sweep, hash stage and key compare
// Bus is ignored for the 64 cycles of the sweep after reset
// Every op gets an ack, also an update whose write bit is clear
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_core #(
    parameter int tbl_idx = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  htable_pkg::bus_word_t bus_word,
    output logic                  init_done,
    output htable_pkg::core_rsp_t rsp
);

    typedef enum logic {
        CORE_INIT,
        CORE_RUN
    } core_state_e;

    core_state_e               state;
    htable_pkg::hash_t         init_addr;

    // Hash stage
    htable_pkg::bus_op_e       s1_op;
    logic                      s1_wr;
    htable_pkg::key_t          s1_key;
    htable_pkg::value_t        s1_value;
    htable_pkg::hash_t         s1_hash;

    // Memory stage
    htable_pkg::bus_op_e       s2_op;
    htable_pkg::key_t          s2_key;

    logic                      mem_en;
    logic                      mem_wr;
    htable_pkg::hash_t         mem_addr;
    htable_pkg::htable_entry_t mem_wdata;
    htable_pkg::htable_entry_t rd_data;
    logic                      hit_now;

    assign init_done = (state == CORE_RUN);

    // ----------------------------------------------------------------
    // Clear sweep, one entry per cycle
    // ----------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= CORE_INIT;
            init_addr <= '0;
        end else if (state == CORE_INIT) begin
            init_addr <= init_addr + 1'b1;
            if (init_addr == htable_pkg::hash_t'(htable_pkg::TABLE_DEPTH - 1)) begin
                state <= CORE_RUN;
            end
        end
    end

    // ----------------------------------------------------------------
    // Pipeline control
    // ----------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_op <= htable_pkg::OP_NONE;
            s1_wr <= 1'b0;
            s2_op <= htable_pkg::OP_NONE;
        end else begin
            s1_op <= (state == CORE_RUN) ? bus_word.op : htable_pkg::OP_NONE;
            // This table's own bit of the write mask
            s1_wr <= bus_word.wr_mask[tbl_idx];
            s2_op <= s1_op;
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        s1_key   <= bus_word.key;
        s1_value <= bus_word.value;
        s1_hash  <= htable_pkg::htable_hash(bus_word.key, tbl_idx);
        s2_key   <= s1_key;
    end

    // Memory port, owned by the sweep until it ends
    always_comb begin
        if (state == CORE_INIT) begin
            mem_en    = 1'b1;
            mem_wr    = 1'b1;
            mem_addr  = init_addr;
            mem_wdata = '0;
        end else begin
            mem_wr    = (s1_op == htable_pkg::OP_UPDATE) && s1_wr;
            mem_en    = mem_wr || (s1_op == htable_pkg::OP_LOOKUP);
            mem_addr  = s1_hash;
            mem_wdata = '{valid: 1'b1, key: s1_key, value: s1_value};
        end
    end

    htable_mem u_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .en      (mem_en),
        .wr      (mem_wr),
        .addr    (mem_addr),
        .wr_data (mem_wdata),
        .rd_data (rd_data)
    );

    // Key compare against the word read in the previous cycle
    assign hit_now = (s2_op == htable_pkg::OP_LOOKUP) && rd_data.valid &&
                     (rd_data.key == s2_key);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp <= '0;
        end else begin
            rsp.ack       <= (s2_op != htable_pkg::OP_NONE);
            rsp.is_update <= (s2_op == htable_pkg::OP_UPDATE);
            rsp.hit       <= hit_now;
            rsp.value     <= hit_now ? rd_data.value : '0;
        end
    end

endmodule : htable_core

//--- htable_multi_core.sv
//--------------------------------------------------------------------
// Three peer table cores on one bus with a combined lookup result
// All cores run one timeline, so table 0 alone supplies the acks
// On several hits the highest-numbered table gives the value
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_multi_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  htable_pkg::bus_word_t bus_word,
    output logic                  init_done,
    output logic                  lookup_ack,
    output logic                  lookup_hit,
    output htable_pkg::value_t    lookup_value,
    output logic                  update_ack
);

    logic [htable_pkg::NUM_TABLES-1:0] core_init_done;
    htable_pkg::core_rsp_t             core_rsp [htable_pkg::NUM_TABLES];

    // ----------------------------------------------------------------
    // Core array, each with its own hash seed
    // ----------------------------------------------------------------
    for (genvar g_tbl = 0; g_tbl < htable_pkg::NUM_TABLES; g_tbl++) begin : g_tbl_core
        htable_core #(
            .tbl_idx (g_tbl)
        ) u_core (
            .clk       (clk),
            .arst_n    (arst_n),
            .bus_word  (bus_word),
            .init_done (core_init_done[g_tbl]),
            .rsp       (core_rsp[g_tbl])
        );
    end : g_tbl_core

    // Ready only once every table is cleared
    assign init_done  = &core_init_done;

    assign lookup_ack = core_rsp[0].ack & ~core_rsp[0].is_update;
    assign update_ack = core_rsp[0].ack & core_rsp[0].is_update;

    // Later tables override earlier ones, value stays zero on a miss
    always_comb begin
        lookup_hit   = 1'b0;
        lookup_value = '0;
        for (int i = 0; i < htable_pkg::NUM_TABLES; i++) begin
            if (core_rsp[i].hit) begin
                lookup_hit   = 1'b1;
                lookup_value = core_rsp[i].value;
            end
        end
    end

endmodule : htable_multi_core

//--- htable_top.sv
//--------------------------------------------------------------------
// Multi-table hash lookup block, 16-bit key and 16-bit value
// Strobes are single cycle and only legal while the matching rdy is high
// Ack follows the sampling edge by 3 cycles on an idle bus
//--------------------------------------------------------------------
`timescale 1ns/1ns

module htable_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     lookup_req,
    input  htable_pkg::key_t         lookup_key,
    input  logic                     update_req,
    input  htable_pkg::key_t         update_key,
    input  htable_pkg::value_t       update_value,
    input  htable_pkg::insert_mode_e update_mode,
    output logic                     lookup_rdy,
    output logic                     update_rdy,
    output logic                     lookup_ack,
    output logic                     lookup_hit,
    output htable_pkg::value_t       lookup_value,
    output logic                     update_ack,
    output logic                     init_done
);

    htable_pkg::bus_req_t  bus_req;
    htable_pkg::bus_word_t bus_word;

    // Bus owner for each cycle
    htable_arb u_arb (
        .clk          (clk),
        .arst_n       (arst_n),
        .init_done    (init_done),
        .lookup_req   (lookup_req),
        .lookup_key   (lookup_key),
        .update_req   (update_req),
        .update_key   (update_key),
        .update_value (update_value),
        .update_mode  (update_mode),
        .lookup_rdy   (lookup_rdy),
        .update_rdy   (update_rdy),
        .bus_req      (bus_req)
    );

    // Insert mode to write mask
    htable_update_dist u_dist (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus_req  (bus_req),
        .bus_word (bus_word)
    );

    htable_multi_core u_multi_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .bus_word     (bus_word),
        .init_done    (init_done),
        .lookup_ack   (lookup_ack),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .update_ack   (update_ack)
    );

endmodule : htable_top

//--- tb_htable_top.sv
//----------------------------------------------------------------------
// Self-checking testbench for the multi-table hash lookup block
// Stimulus rows carry hand-worked expected lookup results
// Acks are checked in bus order against a fixed 3-cycle latency,
// 4 cycles for the loser of a same-cycle lookup and update
//----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_htable_top;

    typedef enum logic [1:0] {
        ROW_LOOKUP,
        ROW_UPDATE,
        ROW_BOTH
    } row_kind_e;

    // One stimulus row, expected fields only matter for lookups
    typedef struct packed {
        row_kind_e                kind;
        htable_pkg::key_t         key;
        htable_pkg::value_t       value;
        htable_pkg::insert_mode_e mode;
        logic                     exp_hit;
        htable_pkg::value_t       exp_value;
    } stim_row_t;

    // One ack the monitor waits for
    typedef struct packed {
        logic               is_update;
        logic               exp_hit;
        htable_pkg::value_t exp_value;
        logic [31:0]        due_cycle;
    } exp_ack_t;

    logic                     clk;
    logic                     arst_n;
    logic                     lookup_req;
    htable_pkg::key_t         lookup_key;
    logic                     update_req;
    htable_pkg::key_t         update_key;
    htable_pkg::value_t       update_value;
    htable_pkg::insert_mode_e update_mode;
    logic                     lookup_rdy;
    logic                     update_rdy;
    logic                     lookup_ack;
    logic                     lookup_hit;
    htable_pkg::value_t       lookup_value;
    logic                     update_ack;
    logic                     init_done;

    int        cycle = 0;
    int        cycle_limit = 0;
    int        reset_cycle;
    logic      last_was_update;
    stim_row_t main_rows [$];
    stim_row_t pair_rows [$];
    exp_ack_t  exp_q [$];

    htable_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_req   (lookup_req),
        .lookup_key   (lookup_key),
        .update_req   (update_req),
        .update_key   (update_key),
        .update_value (update_value),
        .update_mode  (update_mode),
        .lookup_rdy   (lookup_rdy),
        .update_rdy   (update_rdy),
        .lookup_ack   (lookup_ack),
        .lookup_hit   (lookup_hit),
        .lookup_value (lookup_value),
        .update_ack   (update_ack),
        .init_done    (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle_limit > 0 && cycle >= cycle_limit) begin
            $display("Run did not end within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Check failed");
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_lookup_result(input logic got_ack, input logic got_hit,
                                       input htable_pkg::value_t got_value,
                                       input logic exp_hit, input htable_pkg::value_t exp_value);
        check_level("lookup_ack", got_ack, 1'b1);
        check_level("lookup_hit", got_hit, exp_hit);
        if (got_value !== exp_value) begin
            stop_on_error($sformatf("[ERROR] lookup_value got %h expected %h",
                                    got_value, exp_value));
        end
    endtask

    task automatic check_update_ack(input logic got_ack, input logic got_lookup_ack);
        check_level("update_ack", got_ack, 1'b1);
        check_level("lookup_ack", got_lookup_ack, 1'b0);
    endtask

    // Every ack is matched against the oldest outstanding request
    always @(negedge clk) begin : ack_monitor
        exp_ack_t head;
        if (arst_n && (lookup_ack || update_ack)) begin
            if (exp_q.size() == 0) begin
                stop_on_error("An ack arrived with no request outstanding");
            end else begin
                head = exp_q.pop_front();
                if (cycle != head.due_cycle) begin
                    stop_on_error($sformatf("Ack came at cycle %0d instead of cycle %0d",
                                            cycle, head.due_cycle));
                end
                if (head.is_update) begin
                    check_update_ack(update_ack, lookup_ack);
                end else begin
                    check_lookup_result(lookup_ack, lookup_hit, lookup_value,
                                        head.exp_hit, head.exp_value);
                end
            end
        end else if (exp_q.size() != 0 && cycle > exp_q[0].due_cycle) begin
            stop_on_error("An expected ack never arrived");
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    function automatic stim_row_t make_row(input row_kind_e kind, input htable_pkg::key_t key,
                                           input htable_pkg::value_t value, input logic rr,
                                           input logic exp_hit,
                                           input htable_pkg::value_t exp_value);
        stim_row_t row;
        row.kind      = kind;
        row.key       = key;
        row.value     = value;
        row.mode      = rr ? htable_pkg::MODE_ROUND_ROBIN : htable_pkg::MODE_BROADCAST;
        row.exp_hit   = exp_hit;
        row.exp_value = exp_value;
        return row;
    endfunction

    task automatic build_stimulus();
        // Broadcast insert, hit, then a key never inserted
        main_rows.push_back(make_row(ROW_UPDATE, 16'h1234, 16'haaaa, 1'b0, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h1234, 16'h0000, 1'b0, 1'b1, 16'haaaa));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h5555, 16'h0000, 1'b0, 1'b0, 16'h0000));
        // Round robin into tables 0, 1 and 2
        main_rows.push_back(make_row(ROW_UPDATE, 16'h0100, 16'h1111, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_UPDATE, 16'h0200, 16'h2222, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_UPDATE, 16'h0300, 16'h3333, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h0100, 16'h0000, 1'b0, 1'b1, 16'h1111));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h0200, 16'h0000, 1'b0, 1'b1, 16'h2222));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h0300, 16'h0000, 1'b0, 1'b1, 16'h3333));
        // 0004 shares index 4 of table 0 with 0100 and evicts it
        main_rows.push_back(make_row(ROW_UPDATE, 16'h0004, 16'h4444, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h0100, 16'h0000, 1'b0, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h0004, 16'h0000, 1'b0, 1'b1, 16'h4444));
        // Table 1 gets bbbb, table 2 still holds aaaa and wins
        main_rows.push_back(make_row(ROW_UPDATE, 16'h1234, 16'hbbbb, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h1234, 16'h0000, 1'b0, 1'b1, 16'haaaa));
        main_rows.push_back(make_row(ROW_UPDATE, 16'h1234, 16'hcccc, 1'b1, 1'b0, 16'h0000));
        main_rows.push_back(make_row(ROW_LOOKUP, 16'h1234, 16'h0000, 1'b0, 1'b1, 16'hcccc));

        // Same-cycle pairs, last grant before the first pair is a lookup
        pair_rows.push_back(make_row(ROW_BOTH, 16'h1234, 16'hdddd, 1'b0, 1'b1, 16'hdddd));
        pair_rows.push_back(make_row(ROW_UPDATE, 16'h0777, 16'h7777, 1'b0, 1'b0, 16'h0000));
        // Lookup wins this time and still sees dddd
        pair_rows.push_back(make_row(ROW_BOTH, 16'h1234, 16'heeee, 1'b0, 1'b1, 16'hdddd));
        pair_rows.push_back(make_row(ROW_LOOKUP, 16'h1234, 16'h0000, 1'b0, 1'b1, 16'heeee));
        pair_rows.push_back(make_row(ROW_LOOKUP, 16'h0777, 16'h0000, 1'b0, 1'b1, 16'h7777));
    endtask

    task automatic push_lookup_exp(input stim_row_t row, input int due);
        exp_ack_t ack;
        ack.is_update = 1'b0;
        ack.exp_hit   = row.exp_hit;
        ack.exp_value = row.exp_value;
        ack.due_cycle = due;
        exp_q.push_back(ack);
    endtask

    task automatic push_update_exp(input int due);
        exp_ack_t ack;
        ack.is_update = 1'b1;
        ack.exp_hit   = 1'b0;
        ack.exp_value = '0;
        ack.due_cycle = due;
        exp_q.push_back(ack);
    endtask

    // One strobe, called on a falling edge
    task automatic drive_single(input stim_row_t row);
        if (row.kind == ROW_LOOKUP) begin
            while (!lookup_rdy) @(negedge clk);
            lookup_req = 1'b1;
            lookup_key = row.key;
            push_lookup_exp(row, cycle + 4);
            last_was_update = 1'b0;
        end else begin
            while (!update_rdy) @(negedge clk);
            update_req   = 1'b1;
            update_key   = row.key;
            update_value = row.value;
            update_mode  = row.mode;
            push_update_exp(cycle + 4);
            last_was_update = 1'b1;
        end
        @(negedge clk);
        lookup_req = 1'b0;
        update_req = 1'b0;
    endtask

    // Lookup and update of one key in the same cycle
    task automatic drive_pair(input stim_row_t row);
        logic update_wins;
        while (!(lookup_rdy && update_rdy)) @(negedge clk);
        update_wins  = !last_was_update;
        lookup_req   = 1'b1;
        lookup_key   = row.key;
        update_req   = 1'b1;
        update_key   = row.key;
        update_value = row.value;
        update_mode  = row.mode;
        if (update_wins) begin
            push_update_exp(cycle + 4);
            push_lookup_exp(row, cycle + 5);
        end else begin
            push_lookup_exp(row, cycle + 4);
            push_update_exp(cycle + 5);
        end
        last_was_update = !update_wins;
        @(negedge clk);
        lookup_req = 1'b0;
        update_req = 1'b0;
        // Loser sits in its slot for one cycle
        check_level("lookup_rdy", lookup_rdy, !update_wins);
        check_level("update_rdy", update_rdy, update_wins);
        @(negedge clk);
        check_level("lookup_rdy", lookup_rdy, 1'b1);
        check_level("update_rdy", update_rdy, 1'b1);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(92808));
        arst_n       = 1'b0;
        lookup_req   = 1'b0;
        lookup_key   = '0;
        update_req   = 1'b0;
        update_key   = '0;
        update_value = '0;
        update_mode  = htable_pkg::MODE_BROADCAST;
        // Arbiter favours the lookup after reset
        last_was_update = 1'b1;

        build_stimulus();
        if (htable_pkg::htable_hash(16'h0004, 0) != htable_pkg::htable_hash(16'h0100, 0)) begin
            stop_on_error("Keys 0004 and 0100 do not share a table 0 index");
        end
        if (htable_pkg::htable_hash(16'h0300, 2) == htable_pkg::htable_hash(16'h1234, 2)) begin
            stop_on_error("Key 0300 would evict key 1234 from table 2");
        end
        cycle_limit = htable_pkg::TABLE_DEPTH + (main_rows.size() + pair_rows.size()) * 6 + 200;

        // Reset for 8 cycles with all outputs quiet
        repeat (8) begin
            @(negedge clk);
            check_level("init_done", init_done, 1'b0);
            check_level("lookup_rdy", lookup_rdy, 1'b0);
            check_level("update_rdy", update_rdy, 1'b0);
        end
        arst_n      = 1'b1;
        reset_cycle = cycle;

        // Clear sweep, rdy and acks stay low
        while (!init_done) begin
            check_level("lookup_rdy", lookup_rdy, 1'b0);
            check_level("update_rdy", update_rdy, 1'b0);
            check_level("lookup_ack", lookup_ack, 1'b0);
            check_level("update_ack", update_ack, 1'b0);
            @(negedge clk);
        end
        if (cycle - reset_cycle != htable_pkg::TABLE_DEPTH) begin
            stop_on_error($sformatf("init_done rose %0d cycles after reset instead of %0d",
                                    cycle - reset_cycle, htable_pkg::TABLE_DEPTH));
        end

        foreach (main_rows[i]) begin
            drive_single(main_rows[i]);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end

        // Second pass with same-cycle strobes
        foreach (pair_rows[i]) begin
            if (pair_rows[i].kind == ROW_BOTH) begin
                drive_pair(pair_rows[i]);
            end else begin
                drive_single(pair_rows[i]);
            end
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end

        // Drain, then a few idle cycles to catch stray acks
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_htable_top

//--- project.f
htable_pkg.sv
htable_mem.sv
htable_arb.sv
htable_update_dist.sv
htable_core.sv
htable_multi_core.sv
htable_top.sv
tb_htable_top.sv
